// ==== common/div_config.svh ====
`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// width of every operand, result and bus word
`define DIV_WIDTH 32

// the cache holds 2**DIV_CACHE_IDX_W entries and is indexed by key word bits
`define DIV_CACHE_IDX_W 6
`define DIV_KEY_LSB 2

// byte address width of the slave port
`define DIV_ADR_W 5

// register map as byte offsets
`define DIV_REG_DIVIDEND 5'h00
`define DIV_REG_DIVISOR 5'h04
`define DIV_REG_KEY 5'h08
`define DIV_REG_CTRL 5'h0C
`define DIV_REG_QUOT 5'h10
`define DIV_REG_REM 5'h14

// bit positions in the status word read back from the control offset
`define DIV_STAT_BUSY 0
`define DIV_STAT_HIT 1

`endif

// ==== common/div_pkg.sv ====
`include "div_config.svh"

package div_pkg;

	// one unsigned word as software sees it
	typedef logic [`DIV_WIDTH-1:0] operand_t;

	// reciprocal held as floor(2**32 / divisor), a fraction below one
	typedef logic [`DIV_WIDTH-1:0] recip_t;

	// full multiplier output, the upper half carries the quotient estimate
	typedef logic [2*`DIV_WIDTH-1:0] product_t;

	// selects one cache entry
	typedef logic [`DIV_CACHE_IDX_W-1:0] cache_idx_t;

	// bus side types
	typedef logic [`DIV_ADR_W-1:0] wb_adr_t;
	typedef logic [`DIV_WIDTH-1:0] wb_dat_t;

	// reciprocal engine sequence
	typedef enum logic [2:0] {IDLE, LOOKUP, RECIP, WRITE, MULT, EMIT} div_state_t;

	// remainder and correction sequence
	typedef enum logic [1:0] {FIX_IDLE, FIX_REM, FIX_CORR} fix_state_t;

endpackage

// ==== common/div_ifs.sv ====
`timescale 1ns/100ps

// request from the bus slave and the result coming back from the fix-up stage
interface div_req_if import div_pkg::*; ();
	logic start;
	operand_t dividend;
	operand_t divisor;
	operand_t key;
	logic busy;
	logic done;
	operand_t quotient;
	operand_t remainder;
	logic hit;

	modport slave (output start, dividend, divisor, key,
		input busy, done, quotient, remainder, hit);
	// the engine also watches done so that it knows when to drop busy
	modport engine (input start, dividend, divisor, key, done, output busy);
	modport result (output done, quotient, remainder, hit);
endinterface

// quotient estimate handed from the engine to the fix-up stage
interface div_est_if import div_pkg::*; ();
	logic est_valid;
	operand_t quotient;
	operand_t dividend;
	operand_t divisor;
	logic hit;

	modport source (output est_valid, quotient, dividend, divisor, hit);
	modport sink (input est_valid, quotient, dividend, divisor, hit);
endinterface

// ==== source/wb_div_slave.sv ====
`timescale 1ns/100ps
`include "div_config.svh"

module wb_div_slave import div_pkg::*; (
	input logic clk,
	input logic rst,
	input wb_adr_t wb_adr,
	input wb_dat_t wb_dat_w,
	output wb_dat_t wb_dat_r,
	input logic wb_we,
	input logic wb_stb,
	input logic wb_cyc,
	output logic wb_ack,
	div_req_if.slave req
);
	logic access;
	logic launch;
	logic start_q;
	logic stat_busy;
	logic last_hit;
	operand_t dvd_q;
	operand_t dvs_q;
	operand_t key_q;
	operand_t quot_q;
	operand_t rem_q;
	wb_dat_t status;

	// a cycle counts as a new access only while ack is low
	// so a master holding stb into the ack cycle is served once
	assign access = wb_cyc && wb_stb && !wb_ack;

	// control write with the go bit while nothing is in flight
	// a request that arrives while busy is acked and dropped here
	assign launch = access && wb_we && (wb_adr == `DIV_REG_CTRL) && wb_dat_w[0]
		&& !stat_busy && !req.busy;

	always_comb begin
		status = '0;
		status[`DIV_STAT_BUSY] = stat_busy;
		status[`DIV_STAT_HIT] = last_hit;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_ack <= 1'b0;
			start_q <= 1'b0;
			stat_busy <= 1'b0;
			last_hit <= 1'b0;
			quot_q <= '0;
			rem_q <= '0;
		end else begin
			wb_ack <= access;
			start_q <= launch;
			if (launch) begin
				stat_busy <= 1'b1;
			end
			// done never lines up with a launch because launch needs busy low
			if (req.done) begin
				stat_busy <= 1'b0;
				last_hit <= req.hit;
				quot_q <= req.quotient;
				rem_q <= req.remainder;
			end
		end
	end

	// operand registers may be rewritten while busy
	// the engine took its own copy when the division began
	always_ff @(posedge clk) begin
		if (access && wb_we) begin
			case (wb_adr)
				`DIV_REG_DIVIDEND: dvd_q <= wb_dat_w;
				`DIV_REG_DIVISOR: dvs_q <= wb_dat_w;
				`DIV_REG_KEY: key_q <= wb_dat_w;
				default: ;
			endcase
		end
	end

	// read data is registered and appears together with ack
	always_ff @(posedge clk) begin
		if (access && !wb_we) begin
			case (wb_adr)
				`DIV_REG_DIVIDEND: wb_dat_r <= dvd_q;
				`DIV_REG_DIVISOR: wb_dat_r <= dvs_q;
				`DIV_REG_KEY: wb_dat_r <= key_q;
				`DIV_REG_CTRL: wb_dat_r <= status;
				`DIV_REG_QUOT: wb_dat_r <= quot_q;
				`DIV_REG_REM: wb_dat_r <= rem_q;
				default: wb_dat_r <= '0;
			endcase
		end
	end

	assign req.start = start_q;
	assign req.dividend = dvd_q;
	assign req.divisor = dvs_q;
	assign req.key = key_q;
endmodule

// ==== recip_divider/recip_cache.sv ====
`timescale 1ns/100ps
`include "div_config.svh"

module recip_cache import div_pkg::*; (
	input logic clk,
	input logic rst,
	input cache_idx_t rd_idx,
	input operand_t rd_tag,
	output logic hit,
	output recip_t rd_recip,
	input logic wr_en,
	input cache_idx_t wr_idx,
	input operand_t wr_tag,
	input recip_t wr_recip
);
	localparam int unsigned DEPTH = 1 << `DIV_CACHE_IDX_W;

	// the divisor itself serves as the tag
	operand_t tag_mem [0:DEPTH-1];
	recip_t recip_mem [0:DEPTH-1];
	logic [DEPTH-1:0] valid;

	// valid bits are the only state that reset has to clear
	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0;
		end else if (wr_en) begin
			valid[wr_idx] <= 1'b1;
		end
	end

	// storage and the registered read port
	// a write and a read of the same entry in one cycle returns the old value
	always_ff @(posedge clk) begin
		if (wr_en) begin
			tag_mem[wr_idx] <= wr_tag;
			recip_mem[wr_idx] <= wr_recip;
		end
		rd_recip <= recip_mem[rd_idx];
	end

	// an entry that was never written must not match whatever its tag holds
	always_ff @(posedge clk) begin
		if (rst) begin
			hit <= 1'b0;
		end else begin
			hit <= valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
		end
	end
endmodule

// ==== recip_divider/recip_div_engine.sv ====
`timescale 1ns/100ps
`include "div_config.svh"

module recip_div_engine import div_pkg::*; (
	input logic clk,
	input logic rst,
	div_req_if.engine req,
	div_est_if.source est,
	input logic fix_busy,
	output cache_idx_t rd_idx,
	output operand_t rd_tag,
	input logic hit,
	input recip_t rd_recip,
	output logic wr_en,
	output cache_idx_t wr_idx,
	output operand_t wr_tag,
	output recip_t wr_recip
);
	// one step per quotient bit of 2**32, bit 32 included
	localparam logic [5:0] RECIP_STEPS = 6'd33;

	div_state_t state;
	logic busy_q;
	logic hit_q;
	logic [5:0] cnt;
	operand_t dvd_q;
	operand_t dvs_q;
	operand_t est_q;
	cache_idx_t idx_q;
	recip_t recip_q;
	logic [`DIV_WIDTH:0] rem_q;
	logic step_ge;
	operand_t step_rem;
	product_t prod;

	// the lookup is issued in the start cycle straight from the request
	assign rd_idx = req.key[`DIV_KEY_LSB +: `DIV_CACHE_IDX_W];
	assign rd_tag = req.divisor;

	// restoring step, the partial remainder is one bit wider than the divisor
	assign step_ge = rem_q >= {1'b0, dvs_q};
	assign step_rem = step_ge ? operand_t'(rem_q - {1'b0, dvs_q}) : rem_q[`DIV_WIDTH-1:0];

	// only the upper half is kept, that is floor(dividend * recip / 2**32)
	assign prod = product_t'(recip_q) * product_t'(dvd_q);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			busy_q <= 1'b0;
			hit_q <= 1'b0;
			cnt <= '0;
		end else begin
			if (req.done) begin
				busy_q <= 1'b0;
			end
			case (state)
				IDLE: begin
					if (req.start) begin
						busy_q <= 1'b1;
						hit_q <= 1'b0;
						// divisors of zero and one skip the cache entirely
						if (req.divisor[`DIV_WIDTH-1:1] == '0) begin
							state <= EMIT;
						end else begin
							state <= LOOKUP;
						end
					end
				end
				LOOKUP: begin
					if (hit) begin
						hit_q <= 1'b1;
						state <= MULT;
					end else begin
						cnt <= RECIP_STEPS;
						state <= RECIP;
					end
				end
				RECIP: begin
					cnt <= cnt - 6'd1;
					if (cnt == 6'd1) begin
						state <= WRITE;
					end
				end
				WRITE: state <= MULT;
				MULT: state <= EMIT;
				// hold the estimate until the fix-up stage can take it
				EMIT: begin
					if (!fix_busy) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			IDLE: begin
				if (req.start) begin
					dvd_q <= req.dividend;
					dvs_q <= req.divisor;
					idx_q <= req.key[`DIV_KEY_LSB +: `DIV_CACHE_IDX_W];
					// special answers, a normal division overwrites this in MULT
					est_q <= (req.divisor == '0) ? '1 : req.dividend;
				end
			end
			LOOKUP: begin
				// on a miss the loop starts from remainder one, the leading bit of 2**32
				recip_q <= hit ? rd_recip : '0;
				rem_q <= {{`DIV_WIDTH{1'b0}}, 1'b1};
			end
			RECIP: begin
				// after the last step bit 32 of the quotient has shifted out the top
				recip_q <= {recip_q[`DIV_WIDTH-2:0], step_ge};
				rem_q <= {step_rem, 1'b0};
			end
			MULT: est_q <= prod[2*`DIV_WIDTH-1:`DIV_WIDTH];
			default: ;
		endcase
	end

	// the cache entry is written in the single WRITE cycle
	assign wr_en = state == WRITE;
	assign wr_idx = idx_q;
	assign wr_tag = dvs_q;
	assign wr_recip = recip_q;

	assign req.busy = busy_q;
	assign est.est_valid = (state == EMIT) && !fix_busy;
	assign est.quotient = est_q;
	assign est.dividend = dvd_q;
	assign est.divisor = dvs_q;
	assign est.hit = hit_q;
endmodule

// ==== recip_divider/quotient_fixup.sv ====
`timescale 1ns/100ps

module quotient_fixup import div_pkg::*; (
	input logic clk,
	input logic rst,
	div_est_if.sink est,
	div_req_if.result res,
	output logic busy
);
	fix_state_t state;
	operand_t quot_q;
	operand_t dvd_q;
	operand_t dvs_q;
	operand_t rem_q;
	logic hit_q;
	logic corr;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= FIX_IDLE;
		end else begin
			case (state)
				FIX_IDLE: begin
					if (est.est_valid) begin
						state <= FIX_REM;
					end
				end
				FIX_REM: state <= FIX_CORR;
				FIX_CORR: state <= FIX_IDLE;
				default: state <= FIX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == FIX_IDLE && est.est_valid) begin
			quot_q <= est.quotient;
			dvd_q <= est.dividend;
			dvs_q <= est.divisor;
			hit_q <= est.hit;
		end
		// the estimate is never above the true quotient so this cannot wrap
		if (state == FIX_REM) begin
			rem_q <= dvd_q - operand_t'(dvs_q * quot_q);
		end
	end

	// the estimate is at most one too low, so one compare settles it
	// a zero divisor must pass through since every remainder would compare high
	assign corr = (dvs_q != '0) && (rem_q >= dvs_q);

	// results stay on these outputs until the next estimate arrives
	assign res.done = state == FIX_CORR;
	assign res.quotient = corr ? quot_q + operand_t'(1) : quot_q;
	assign res.remainder = corr ? rem_q - dvs_q : rem_q;
	assign res.hit = hit_q;

	assign busy = state != FIX_IDLE;
endmodule

// ==== source/div_top.sv ====
`timescale 1ns/100ps

module div_top import div_pkg::*; (
	input logic clk,
	input logic rst,
	input wb_adr_t wb_adr,
	input wb_dat_t wb_dat_w,
	output wb_dat_t wb_dat_r,
	input logic wb_we,
	input logic wb_stb,
	input logic wb_cyc,
	output logic wb_ack
);
	// cache port between the engine and its store
	cache_idx_t rd_idx;
	operand_t rd_tag;
	logic cache_hit;
	recip_t rd_recip;
	logic wr_en;
	cache_idx_t wr_idx;
	operand_t wr_tag;
	recip_t wr_recip;
	logic fix_busy;

	div_req_if req_if ();
	div_est_if est_if ();

	// bus side takes the operands and hands back results
	wb_div_slave slave0 (
		.clk(clk),
		.rst(rst),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_we(wb_we),
		.wb_stb(wb_stb),
		.wb_cyc(wb_cyc),
		.wb_ack(wb_ack),
		.req(req_if.slave)
	);

	recip_div_engine engine0 (
		.clk(clk),
		.rst(rst),
		.req(req_if.engine),
		.est(est_if.source),
		.fix_busy(fix_busy),
		.rd_idx(rd_idx),
		.rd_tag(rd_tag),
		.hit(cache_hit),
		.rd_recip(rd_recip),
		.wr_en(wr_en),
		.wr_idx(wr_idx),
		.wr_tag(wr_tag),
		.wr_recip(wr_recip)
	);

	recip_cache cache0 (
		.clk(clk),
		.rst(rst),
		.rd_idx(rd_idx),
		.rd_tag(rd_tag),
		.hit(cache_hit),
		.rd_recip(rd_recip),
		.wr_en(wr_en),
		.wr_idx(wr_idx),
		.wr_tag(wr_tag),
		.wr_recip(wr_recip)
	);

	// final stage drives done and the exact results back to the slave
	quotient_fixup fixup0 (
		.clk(clk),
		.rst(rst),
		.est(est_if.sink),
		.res(req_if.result),
		.busy(fix_busy)
	);
endmodule

// ==== verification/div_assertions.sv ====
`timescale 1ns/100ps

module div_assertions import div_pkg::*; (
	input logic clk,
	input logic rst,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input logic start,
	input logic busy,
	input logic done,
	input operand_t dividend,
	input operand_t divisor,
	input operand_t quotient,
	input operand_t remainder
);
	// a fresh access is answered on the very next edge
	ack_after_access: assert property (@(posedge clk) disable iff (rst)
		(wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
		else $error("ack missing one cycle after a bus access");

	// ack is a single cycle pulse
	ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
		wb_ack |=> !wb_ack)
		else $error("ack held longer than one cycle");

	// no ack without a request in the cycle before
	ack_requested: assert property (@(posedge clk) disable iff (rst)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else $error("ack without a preceding bus access");

	// a new division may only begin while the engine is idle
	start_when_idle: assert property (@(posedge clk) disable iff (rst)
		start |-> !busy)
		else $error("start issued while the engine was busy");

	// every finished division satisfies q * d + r == n with r below d
	result_identity: assert property (@(posedge clk) disable iff (rst)
		(done && divisor != '0) |->
			((product_t'(quotient) * product_t'(divisor) + product_t'(remainder)
				== product_t'(dividend)) && (remainder < divisor)))
		else $error("quotient and remainder do not rebuild the dividend");
endmodule

// bus and start checks live on the slave, the result identity on the fix-up stage
// ports that one side does not use are tied off so those properties never trigger
bind wb_div_slave div_assertions slave_chk (
	.clk(clk),
	.rst(rst),
	.wb_cyc(wb_cyc),
	.wb_stb(wb_stb),
	.wb_ack(wb_ack),
	.start(req.start),
	.busy(req.busy),
	.done(1'b0),
	.dividend('0),
	.divisor('0),
	.quotient('0),
	.remainder('0)
);

bind quotient_fixup div_assertions fixup_chk (
	.clk(clk),
	.rst(rst),
	.wb_cyc(1'b0),
	.wb_stb(1'b0),
	.wb_ack(1'b0),
	.start(1'b0),
	.busy(1'b0),
	.done(res.done),
	.dividend(dvd_q),
	.divisor(dvs_q),
	.quotient(res.quotient),
	.remainder(res.remainder)
);

// ==== verification/div_tb.sv ====
`timescale 1ns/100ps
`include "div_config.svh"

module div_tb import div_pkg::*; ();
	// roughly 70 divisions of up to 55 cycles each with some margin on top
	localparam int unsigned MAX_CYCLES = 5000;
	localparam int unsigned DEPTH = 1 << `DIV_CACHE_IDX_W;
	// the miss and hit tests use a fresh key at index 0 after reset
	localparam operand_t MISS_KEY = 32'h0000_1000;

	logic clk;
	logic rst;
	wb_adr_t wb_adr;
	wb_dat_t wb_dat_w;
	wb_dat_t wb_dat_r;
	logic wb_we;
	logic wb_stb;
	logic wb_cyc;
	logic wb_ack;

	int unsigned cycle_count = 0;
	operand_t rng;
	operand_t saved_divisor;
	// expected cache contents with each entry tagged by its divisor
	operand_t tag_model [0:DEPTH-1];
	logic [DEPTH-1:0] valid_model;

	div_top dut0 (
		.clk(clk),
		.rst(rst),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_we(wb_we),
		.wb_stb(wb_stb),
		.wb_cyc(wb_cyc),
		.wb_ack(wb_ack)
	);

	always #5 clk = ~clk;

	// hard limit on the run so a stuck divider cannot hang the simulation
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
			$display("Checks failed");
			$fatal(1, "cycle limit reached");
		end
	end

	function automatic operand_t xorshift(input operand_t x);
		operand_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic next_random(output operand_t value);
		rng = xorshift(rng);
		value = rng;
	endtask

	task automatic abort_run();
		$display("Checks failed");
		$fatal(1, "stopped at the first failing check");
	endtask

	task automatic check_operand(input string what, input operand_t got, input operand_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_word(input string what, input wb_dat_t got, input wb_dat_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s reads %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	// every bus task starts 1 ns after a rising edge and returns at that point too
	task automatic wb_write(input wb_adr_t adr, input wb_dat_t data);
		wb_adr = adr;
		wb_dat_w = data;
		wb_we = 1'b1;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		// ack is registered, so look at it just after each edge
		do begin
			@(posedge clk);
			#1;
		end while (!wb_ack);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_read(input wb_adr_t adr, output wb_dat_t data);
		wb_adr = adr;
		wb_we = 1'b0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		do begin
			@(posedge clk);
			#1;
		end while (!wb_ack);
		data = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		// reset empties the cache
		valid_model = '0;
	endtask

	task automatic divide(input operand_t key, input operand_t dividend, input operand_t divisor,
		output operand_t quotient, output operand_t remainder, output logic hit);
		wb_dat_t status;
		wb_write(`DIV_REG_DIVIDEND, dividend);
		wb_write(`DIV_REG_DIVISOR, divisor);
		wb_write(`DIV_REG_KEY, key);
		wb_write(`DIV_REG_CTRL, 32'h1);
		// the status read also shows the hit bit of the finished division
		do begin
			wb_read(`DIV_REG_CTRL, status);
		end while (status[`DIV_STAT_BUSY]);
		wb_read(`DIV_REG_QUOT, quotient);
		wb_read(`DIV_REG_REM, remainder);
		hit = status[`DIV_STAT_HIT];
	endtask

	// divisors zero and one never reach the cache
	function automatic logic predict_hit(input operand_t key, input operand_t divisor);
		logic [5:0] idx;
		idx = key[7:2];
		if (divisor <= 32'd1) begin
			return 1'b0;
		end
		return valid_model[idx] && (tag_model[idx] == divisor);
	endfunction

	task automatic learn_tag(input operand_t key, input operand_t divisor);
		logic [5:0] idx;
		idx = key[7:2];
		if (divisor > 32'd1) begin
			valid_model[idx] = 1'b1;
			tag_model[idx] = divisor;
		end
	endtask

	task automatic run_and_check(input operand_t key, input operand_t dividend,
		input operand_t divisor, input logic exp_hit);
		operand_t quot;
		operand_t rem;
		logic hit;
		operand_t exp_quot;
		operand_t exp_rem;
		// a zero divisor answers all ones and leaves the dividend as remainder
		if (divisor == '0) begin
			exp_quot = '1;
			exp_rem = dividend;
		end else begin
			exp_quot = dividend / divisor;
			exp_rem = dividend % divisor;
		end
		divide(key, dividend, divisor, quot, rem, hit);
		check_operand($sformatf("quotient of %h / %h", dividend, divisor), quot, exp_quot);
		check_operand($sformatf("remainder of %h / %h", dividend, divisor), rem, exp_rem);
		check_flag($sformatf("hit bit for key %h divisor %h", key, divisor), hit, exp_hit);
		learn_tag(key, divisor);
	endtask

	task automatic miss_path();
		operand_t dividend;
		next_random(dividend);
		next_random(saved_divisor);
		saved_divisor = (saved_divisor >> 8) | 32'h2;
		run_and_check(MISS_KEY, dividend, saved_divisor, 1'b0);
	endtask

	task automatic hit_path();
		operand_t dividend;
		next_random(dividend);
		run_and_check(MISS_KEY, dividend, saved_divisor, 1'b1);
		next_random(dividend);
		// the same key with another divisor no longer matches the tag
		run_and_check(MISS_KEY, dividend, saved_divisor + 32'd3, 1'b0);
	endtask

	task automatic special_divisors();
		operand_t dividend;
		next_random(dividend);
		// a hit right before shows that a special divisor clears the hit bit again
		run_and_check(MISS_KEY, dividend, saved_divisor + 32'd3, 1'b1);
		run_and_check(32'h0000_1100, dividend, 32'd1, 1'b0);
		run_and_check(32'h0000_1100, dividend, 32'd0, 1'b0);
		run_and_check(32'h0000_1104, 32'hFFFF_FFFF, 32'd0, 1'b0);
	endtask

	// low reciprocal estimates that the fix-up stage has to raise by one
	task automatic correction_cases();
		operand_t divisors [6];
		operand_t dividends [3];
		operand_t key;
		divisors = '{32'h2, 32'h0001_0000, 32'h8000_0000,
			32'hFFFF_FFFF, 32'hFFFF_FFFE, 32'h8000_0001};
		dividends = '{32'h0, 32'h1, 32'hFFFF_FFFF};
		for (int d = 0; d < 6; d++) begin
			key = 32'h0000_2000 + operand_t'(d) * 32'h4;
			for (int n = 0; n < 3; n++) begin
				run_and_check(key, dividends[n], divisors[d], predict_hit(key, divisors[d]));
			end
		end
	endtask

	task automatic alias_and_reset();
		wb_dat_t word;
		// keys 0x40 and 0x140 share cache index 16
		run_and_check(32'h0000_0040, 32'd123_456_789, 32'd7, 1'b0);
		run_and_check(32'h0000_0140, 32'd987_654_321, 32'd1_000_003, 1'b0);
		run_and_check(32'h0000_0040, 32'd55_555, 32'd7, 1'b0);
		run_and_check(32'h0000_0140, 32'd42, 32'd1_000_003, 1'b0);
		run_and_check(32'h0000_0140, 32'hDEAD_BEEF, 32'd1_000_003, 1'b1);
		apply_reset();
		wb_read(`DIV_REG_CTRL, word);
		check_word("status after reset", word, '0);
		wb_read(`DIV_REG_QUOT, word);
		check_word("quotient after reset", word, '0);
		wb_read(`DIV_REG_REM, word);
		check_word("remainder after reset", word, '0);
		run_and_check(32'h0000_0140, 32'hDEAD_BEEF, 32'd1_000_003, 1'b0);
	endtask

	task automatic random_sweep();
		operand_t key;
		operand_t dividend;
		operand_t divisor;
		operand_t pick;
		logic [5:0] idx;
		for (int i = 0; i < 40; i++) begin
			next_random(pick);
			key = 32'h0000_4000 + operand_t'(pick[2:0]) * 32'h90;
			idx = key[7:2];
			next_random(dividend);
			next_random(divisor);
			// now and then reuse the cached divisor at this key so that hits occur
			if (pick[8] && valid_model[idx]) begin
				divisor = tag_model[idx];
			end else begin
				divisor = divisor >> pick[20:16];
			end
			run_and_check(key, dividend, divisor, predict_hit(key, divisor));
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		wb_adr = '0;
		wb_dat_w = '0;
		wb_we = 1'b0;
		wb_stb = 1'b0;
		wb_cyc = 1'b0;
		rng = 32'h7160;
		apply_reset();
		miss_path();
		hit_path();
		special_divisors();
		correction_cases();
		alias_and_reset();
		random_sweep();
		$display("All checks passed");
		$finish;
	end
endmodule

// ==== project.f ====
+incdir+common
common/div_pkg.sv
common/div_ifs.sv
source/wb_div_slave.sv
recip_divider/recip_cache.sv
recip_divider/recip_div_engine.sv
recip_divider/quotient_fixup.sv
source/div_top.sv
verification/div_assertions.sv
verification/div_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the divider testbench with Verilator and runs it
# the simulator exits nonzero on $fatal or a failed assertion, and set -e passes that on
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module div_tb \
	--Mdir obj_dir -o div_sim

./obj_dir/div_sim
